//--- design/uart_baud_gen.sv
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic [7:0] baud_div,
    output logic            tick
);

    // counts down to zero, then reloads
    logic [7:0] cnt;

    //////////////////////////////////////////////////////////////////////
    // divisor counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt  <= uart_pkg::BAUD_DIV_RESET;
            tick <= 1'b0;
        end else begin
            if (cnt == 8'd0) begin
                // reload point, one pulse per baud_div+1 clocks
                cnt  <= baud_div;
                tick <= 1'b1;
            end else begin
                cnt  <= cnt - 8'd1;
                tick <= 1'b0;
            end
        end
    end

    // a new divisor only takes effect at the next reload,
    // so a running period is never cut short

endmodule

`default_nettype wire

//--- design/uart_controller.sv
`timescale 1ns/1ps
`default_nettype none

module uart_controller (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       wr_en,
    input  wire logic       rd_en,
    input  wire logic [1:0] addr,
    input  wire logic [7:0] wdata,
    output logic [7:0]      rdata,
    input  wire logic       rx,
    output logic            tx
);

    logic [7:0] baud_div;
    logic       tick;

    // receive path
    logic       rx_valid;
    logic [7:0] rx_byte;
    logic       rx_frame_err;
    logic       rx_push;
    logic [7:0] rx_push_data;
    logic       rx_pop;
    logic [7:0] rx_fifo_head;
    logic       rx_fifo_empty;
    logic       rx_fifo_full;

    // transmit path
    logic       tx_push;
    logic [7:0] tx_push_data;
    logic [7:0] tx_fifo_head;
    logic       tx_fifo_empty;
    logic       tx_fifo_full;
    logic       tx_start;
    logic       tx_busy;

    //////////////////////////////////////////////////////////////////////
    // host side
    //////////////////////////////////////////////////////////////////////

    uart_regs regs0 (
        .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .rd_en(rd_en),
        .addr(addr), .wdata(wdata), .rx_valid(rx_valid), .rx_byte(rx_byte),
        .rx_frame_err(rx_frame_err), .rx_fifo_empty(rx_fifo_empty),
        .rx_fifo_full(rx_fifo_full), .rx_fifo_head(rx_fifo_head),
        .tx_fifo_full(tx_fifo_full), .tx_fifo_empty(tx_fifo_empty),
        .tx_busy(tx_busy), .rdata(rdata), .baud_div(baud_div),
        .rx_push(rx_push), .rx_push_data(rx_push_data), .rx_pop(rx_pop),
        .tx_push(tx_push), .tx_push_data(tx_push_data)
    );

    uart_baud_gen baud0 (.clk(clk), .rst_n(rst_n), .baud_div(baud_div), .tick(tick));

    uart_fifo rx_fifo0 (
        .clk(clk), .rst_n(rst_n), .push(rx_push), .push_data(rx_push_data),
        .pop(rx_pop), .head(rx_fifo_head), .empty(rx_fifo_empty), .full(rx_fifo_full)
    );

    uart_fifo tx_fifo0 (
        .clk(clk), .rst_n(rst_n), .push(tx_push), .push_data(tx_push_data),
        .pop(tx_start), .head(tx_fifo_head), .empty(tx_fifo_empty), .full(tx_fifo_full)
    );

    // pop and load in the same cycle
    assign tx_start = !tx_fifo_empty && !tx_busy;

    uart_rx rx0 (
        .clk(clk), .rst_n(rst_n), .rx(rx), .tick(tick),
        .rx_valid(rx_valid), .rx_byte(rx_byte), .rx_frame_err(rx_frame_err)
    );

    uart_tx tx0 (
        .clk(clk), .rst_n(rst_n), .tick(tick), .tx_start(tx_start),
        .tx_data(tx_fifo_head), .tx(tx), .tx_busy(tx_busy)
    );

endmodule

`default_nettype wire

//--- design/uart_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module uart_fifo (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       push,
    input  wire logic [7:0] push_data,
    input  wire logic       pop,
    output logic [7:0]      head,
    output logic            empty,
    output logic            full
);

    logic [7:0]                 mem [0:uart_pkg::FIFO_DEPTH-1];
    // pointers wrap on their own, depth is a power of two
    logic [uart_pkg::FIFO_AW-1:0] wr_ptr;
    logic [uart_pkg::FIFO_AW-1:0] rd_ptr;
    logic [uart_pkg::FIFO_AW:0]   count;

    //////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // both at once leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // first word falls through
    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == uart_pkg::FIFO_DEPTH);

    // the register block gates both strobes
    assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("fifo push while full");
    assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
        else $error("fifo pop while empty");

endmodule

`default_nettype wire

//--- design/uart_pkg.sv
`default_nettype none

package uart_pkg;

    //////////////////////////////////////////////////////////////////////
    // host register map
    //////////////////////////////////////////////////////////////////////

    localparam logic [1:0] ADDR_DATA   = 2'd0;
    localparam logic [1:0] ADDR_STATUS = 2'd1;
    localparam logic [1:0] ADDR_BAUD   = 2'd2;

    // bit positions in the status word, upper bits read zero
    localparam int STAT_RX_AVAIL  = 0;
    localparam int STAT_TX_FULL   = 1;
    localparam int STAT_TX_IDLE   = 2;
    localparam int STAT_OVERRUN   = 3;
    localparam int STAT_FRAME_ERR = 4;

    //////////////////////////////////////////////////////////////////////
    // fifo and baud
    //////////////////////////////////////////////////////////////////////

    localparam int FIFO_AW = 4;
    // count is one bit wider than the pointers
    localparam logic [FIFO_AW:0] FIFO_DEPTH = 5'd16;

    // divisor after reset, tick every div+1 clocks
    localparam logic [7:0] BAUD_DIV_RESET = 8'd3;

    // ticks per serial bit
    localparam int OVERSAMPLE = 16;
    // eighth tick of the start bit, middle of the bit
    localparam logic [3:0] OVS_MID  = 4'(OVERSAMPLE / 2 - 1);
    // last tick of a full bit
    localparam logic [3:0] OVS_LAST = 4'(OVERSAMPLE - 1);

    // receiver states
    localparam logic [1:0] RX_IDLE  = 2'd0;
    localparam logic [1:0] RX_START = 2'd1;
    localparam logic [1:0] RX_DATA  = 2'd2;
    localparam logic [1:0] RX_STOP  = 2'd3;

endpackage

`default_nettype wire

//--- design/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       wr_en,
    input  wire logic       rd_en,
    input  wire logic [1:0] addr,
    input  wire logic [7:0] wdata,
    input  wire logic       rx_valid,
    input  wire logic [7:0] rx_byte,
    input  wire logic       rx_frame_err,
    input  wire logic       rx_fifo_empty,
    input  wire logic       rx_fifo_full,
    input  wire logic [7:0] rx_fifo_head,
    input  wire logic       tx_fifo_full,
    input  wire logic       tx_fifo_empty,
    input  wire logic       tx_busy,
    output logic [7:0]      rdata,
    output logic [7:0]      baud_div,
    output logic            rx_push,
    output logic [7:0]      rx_push_data,
    output logic            rx_pop,
    output logic            tx_push,
    output logic [7:0]      tx_push_data
);

    logic       overrun;
    logic       frame_err;
    logic       stat_rd;
    logic [7:0] status;

    //////////////////////////////////////////////////////////////////////
    // strobe decode, full and empty gating
    //////////////////////////////////////////////////////////////////////

    // dropped when full
    assign tx_push      = wr_en && (addr == uart_pkg::ADDR_DATA) && !tx_fifo_full;
    assign tx_push_data = wdata;
    // empty read pops nothing
    assign rx_pop       = rd_en && (addr == uart_pkg::ADDR_DATA) && !rx_fifo_empty;
    // receiver has no stall, byte lost when full
    assign rx_push      = rx_valid && !rx_fifo_full;
    assign rx_push_data = rx_byte;
    assign stat_rd      = rd_en && (addr == uart_pkg::ADDR_STATUS);

    always_comb begin
        status                           = 8'h00;
        status[uart_pkg::STAT_RX_AVAIL]  = !rx_fifo_empty;
        status[uart_pkg::STAT_TX_FULL]   = tx_fifo_full;
        status[uart_pkg::STAT_TX_IDLE]   = tx_fifo_empty && !tx_busy;
        status[uart_pkg::STAT_OVERRUN]   = overrun;
        status[uart_pkg::STAT_FRAME_ERR] = frame_err;
    end

    // sticky flags, a new event beats the read clear
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            overrun   <= 1'b0;
            frame_err <= 1'b0;
            baud_div  <= uart_pkg::BAUD_DIV_RESET;
        end else begin
            overrun   <= (rx_valid && rx_fifo_full) || (overrun && !stat_rd);
            frame_err <= rx_frame_err || (frame_err && !stat_rd);
            if (wr_en && addr == uart_pkg::ADDR_BAUD) begin
                baud_div <= wdata;
            end
        end
    end

    // read data, held until the next read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata <= 8'h00;
        end else if (rd_en) begin
            case (addr)
                uart_pkg::ADDR_DATA:   rdata <= rx_fifo_empty ? 8'h00 : rx_fifo_head;
                uart_pkg::ADDR_STATUS: rdata <= status;
                uart_pkg::ADDR_BAUD:   rdata <= baud_div;
                default:               rdata <= 8'h00;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && rd_en))
        else $error("host wr_en and rd_en together");

endmodule

`default_nettype wire

//--- design/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       rx,
    input  wire logic       tick,
    output logic            rx_valid,
    output logic [7:0]      rx_byte,
    output logic            rx_frame_err
);

    // two-flop synchronizer plus previous sample for edge detect
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;

    logic [1:0] state;
    logic [3:0] tick_cnt;
    logic [2:0] bit_cnt;
    logic [7:0] shift;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // line idles high
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // frame fsm
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= uart_pkg::RX_IDLE;
            tick_cnt     <= 4'd0;
            bit_cnt      <= 3'd0;
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            // strobes
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: begin
                    // falling edge only, a held-low line does not retrigger
                    if (rx_prev && !rx_sync) begin
                        state    <= uart_pkg::RX_START;
                        tick_cnt <= 4'd0;
                    end
                end
                uart_pkg::RX_START: begin
                    if (tick) begin
                        if (tick_cnt == uart_pkg::OVS_MID) begin
                            // glitch, back to idle with no report
                            tick_cnt <= 4'd0;
                            bit_cnt  <= 3'd0;
                            state    <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                        end else begin
                            tick_cnt <= tick_cnt + 4'd1;
                        end
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (tick) begin
                        if (tick_cnt == uart_pkg::OVS_LAST) begin
                            tick_cnt <= 4'd0;
                            bit_cnt  <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7) begin
                                state <= uart_pkg::RX_STOP;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 4'd1;
                        end
                    end
                end
                default: begin
                    // stop bit, judged at its middle
                    if (tick) begin
                        if (tick_cnt == uart_pkg::OVS_LAST) begin
                            rx_valid     <= rx_sync;
                            rx_frame_err <= !rx_sync;
                            state        <= uart_pkg::RX_IDLE;
                        end else begin
                            tick_cnt <= tick_cnt + 4'd1;
                        end
                    end
                end
            endcase
        end
    end

    // data bits enter at the top, lsb first on the line
    always_ff @(posedge clk) begin
        if (state == uart_pkg::RX_DATA && tick && tick_cnt == uart_pkg::OVS_LAST) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

    assign rx_byte = shift;

    assert property (@(posedge clk) disable iff (!rst_n)
        !(rx_valid && rx_frame_err))
        else $error("rx_valid and rx_frame_err together");

endmodule

`default_nettype wire

//--- design/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       tick,
    input  wire logic       tx_start,
    input  wire logic [7:0] tx_data,
    output logic            tx,
    output logic            tx_busy
);

    // bit 0 is on the line, ones shift in behind
    logic [9:0] frame;
    logic [3:0] tick_cnt;
    // 0 start, 1..8 data, 9 stop
    logic [3:0] bit_cnt;

    //////////////////////////////////////////////////////////////////////
    // frame shifter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // all ones keeps the line idle high
            frame    <= '1;
            tx_busy  <= 1'b0;
            tick_cnt <= 4'd0;
            bit_cnt  <= 4'd0;
        end else if (tx_start && !tx_busy) begin
            // stop, data, start
            frame    <= {1'b1, tx_data, 1'b0};
            tx_busy  <= 1'b1;
            tick_cnt <= 4'd0;
            bit_cnt  <= 4'd0;
        end else if (tx_busy && tick) begin
            if (tick_cnt == uart_pkg::OVS_LAST) begin
                tick_cnt <= 4'd0;
                frame    <= {1'b1, frame[9:1]};
                bit_cnt  <= bit_cnt + 4'd1;
                // end of stop bit, free for the next byte
                if (bit_cnt == 4'd9) begin
                    tx_busy <= 1'b0;
                end
            end else begin
                tick_cnt <= tick_cnt + 4'd1;
            end
        end
    end

    // after ten shifts the register is all ones again
    assign tx = frame[0];

    // start gating lives in the top level
    assert property (@(posedge clk) disable iff (!rst_n)
        !(tx_start && tx_busy))
        else $error("tx_start while transmitter busy");

endmodule

`default_nettype wire

//--- dv/uart_controller_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_controller_tb;

    localparam int MAX_ENTRIES = 128;
    // longest wait for one entry, in bit times
    localparam int WAIT_BITS = 12;

    // opcodes in the top nibble of a test entry
    localparam logic [3:0] OP_WRITE  = 4'h1;
    localparam logic [3:0] OP_READ   = 4'h2;
    localparam logic [3:0] OP_SEND   = 4'h3;
    localparam logic [3:0] OP_EXPECT = 4'h4;
    localparam logic [3:0] OP_IDLE   = 4'h5;
    localparam logic [3:0] OP_QUIET  = 4'h6;

    logic       clk;
    logic       rst_n;
    logic       wr_en;
    logic       rd_en;
    logic [1:0] addr;
    logic [7:0] wdata;
    logic [7:0] rdata;
    logic       rx;
    logic       tx;

    // op, select, byte, expected
    logic [23:0] tests [0:MAX_ENTRIES-1];
    int          n_entries;
    // divisor as the host last wrote it
    logic [7:0]  div_copy;
    int          cycle_cnt;
    int          cycle_limit;
    int          mismatches;
    int          failures;
    // bytes seen on tx, oldest first
    logic [7:0]  tx_seen [$];

    uart_controller dut0 (
        .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .rd_en(rd_en), .addr(addr),
        .wdata(wdata), .rdata(rdata), .rx(rx), .tx(tx)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // host and serial helpers
    //////////////////////////////////////////////////////////////////////

    // clocks per serial bit
    function automatic int bit_clocks();
        return uart_pkg::OVERSAMPLE * (int'(div_copy) + 1);
    endfunction

    task automatic host_write(input logic [1:0] a, input logic [7:0] d);
        @(negedge clk);
        wr_en = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge clk);
        wr_en = 1'b0;
        if (a == uart_pkg::ADDR_BAUD) begin
            div_copy = d;
        end
    endtask

    // rdata is registered, stable one cycle after the strobe
    task automatic host_read(input logic [1:0] a, input logic [7:0] exp);
        @(negedge clk);
        rd_en = 1'b1;
        addr  = a;
        @(negedge clk);
        rd_en = 1'b0;
        if (rdata !== exp) begin
            $display("Mismatch rdata at addr %0d: expected %h got %h", a, exp, rdata);
            mismatches++;
        end
    endtask

    // 8N1 frame on rx, then one idle bit so the byte has landed
    task automatic send_serial(input logic [7:0] b, input logic bad_stop);
        logic [9:0] frame;
        frame = {!bad_stop, b, 1'b0};
        repeat (10) begin
            @(negedge clk);
            rx    = frame[0];
            frame = {1'b1, frame[9:1]};
            repeat (bit_clocks() - 1) @(negedge clk);
        end
        @(negedge clk);
        rx = 1'b1;
        repeat (bit_clocks() - 1) @(negedge clk);
    endtask

    // one tx frame, start edge then mid-bit samples
    task automatic sample_tx_frame();
        logic       prev;
        logic [7:0] b;
        prev = tx;
        b    = 8'h00;
        @(negedge clk);
        while (!(prev && !tx)) begin
            prev = tx;
            @(negedge clk);
        end
        repeat (bit_clocks() / 2) @(negedge clk);
        if (tx !== 1'b0) begin
            $display("tx start bit went high again before its middle");
            failures++;
        end else begin
            // lsb first, shifts in from the top
            repeat (8) begin
                repeat (bit_clocks()) @(negedge clk);
                b = {tx, b[7:1]};
            end
            repeat (bit_clocks()) @(negedge clk);
            if (tx !== 1'b1) begin
                $display("Mismatch tx stop bit: expected %h got %h", 1'b1, tx);
                mismatches++;
            end
            tx_seen.push_back(b);
        end
    endtask

    task automatic expect_tx(input logic [7:0] exp);
        int         waited;
        logic [7:0] got;
        waited = 0;
        while (tx_seen.size() == 0 && waited < WAIT_BITS * bit_clocks()) begin
            @(negedge clk);
            waited++;
        end
        if (tx_seen.size() == 0) begin
            $display("no start edge on tx in %0d bit times, byte %h never came out",
                WAIT_BITS, exp);
            failures++;
        end else begin
            got = tx_seen.pop_front();
            if (got !== exp) begin
                $display("Mismatch tx byte: expected %h got %h", exp, got);
                mismatches++;
            end
        end
    endtask

    // line must stay high and no frame may show up
    task automatic expect_quiet(input int bits);
        int low_cycles;
        low_cycles = 0;
        repeat (bits * bit_clocks()) begin
            @(negedge clk);
            if (tx !== 1'b1) begin
                low_cycles++;
            end
        end
        if (low_cycles != 0) begin
            $display("tx left idle for %0d cycles when no frame was due", low_cycles);
            failures++;
        end
        if (tx_seen.size() != 0) begin
            $display("tx sent %0d frames that were not expected", tx_seen.size());
            failures++;
            tx_seen.delete();
        end
    endtask

    task automatic run_entry(input logic [23:0] e);
        case (e[23:20])
            OP_WRITE:  host_write(e[17:16], e[15:8]);
            OP_READ:   host_read(e[17:16], e[7:0]);
            OP_SEND:   send_serial(e[15:8], e[16]);
            OP_EXPECT: expect_tx(e[7:0]);
            OP_IDLE:   repeat (int'(e[15:8]) * bit_clocks()) @(negedge clk);
            OP_QUIET:  expect_quiet(int'(e[15:8]));
            default: begin
                $display("unknown opcode %h in a test entry", e[23:20]);
                failures++;
            end
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence, tx monitor, watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        int i;
        int max_div;
        wr_en       = 1'b0;
        rd_en       = 1'b0;
        addr        = 2'd0;
        wdata       = 8'h00;
        rx          = 1'b1;
        rst_n       = 1'b0;
        mismatches  = 0;
        failures    = 0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        div_copy    = uart_pkg::BAUD_DIV_RESET;
        for (i = 0; i < MAX_ENTRIES; i++) begin
            tests[i] = 24'h0;
        end
        $readmemh("dv/uart_tests.txt", tests);
        // list ends at the first zero opcode
        n_entries = 0;
        max_div   = int'(uart_pkg::BAUD_DIV_RESET);
        while (n_entries < MAX_ENTRIES && tests[n_entries][23:20] != 4'h0) begin
            if (tests[n_entries][23:20] == OP_WRITE &&
                tests[n_entries][17:16] == uart_pkg::ADDR_BAUD &&
                int'(tests[n_entries][15:8]) > max_div) begin
                max_div = int'(tests[n_entries][15:8]);
            end
            n_entries++;
        end
        if (n_entries == 0) begin
            $display("no test entries were read from dv/uart_tests.txt");
            failures++;
        end
        cycle_limit = n_entries * WAIT_BITS * uart_pkg::OVERSAMPLE * (max_div + 1);
        // two rising edges in reset
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        for (i = 0; i < n_entries; i++) begin
            run_entry(tests[i]);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        @(posedge rst_n);
        @(negedge clk);
        forever sample_tx_frame();
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, errors so far: %0d mismatches, %0d other",
            cycle_limit, mismatches, failures);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/uart_tests.txt
// one entry per line: op, select, byte, expected (hex digits O S BB EE)
// op 1 write S=addr, 2 read S=addr, 3 send BB (S=1 bad stop), 4 expect EE on tx, 5 idle, 6 quiet
210004 // status after reset
220003 // baud after reset
600200 // tx stays high
105500
10a300
400055
4000a3
500100
210004
303c00 // two bytes on rx
308100
210005
20003c
210005
200081
210004
200000 // empty fifo reads zero
301000 // seventeen bytes, no reads
301100
301200
301300
301400
301500
301600
301700
301800
301900
301a00
301b00
301c00
301d00
301e00
301f00
302000
21000d // overrun set
210005 // and cleared by the read
200010
200011
200012
200013
200014
200015
200016
200017
200018
200019
20001a
20001b
20001c
20001d
20001e
20001f
200000 // seventeenth byte was lost
210004
31e700 // low stop bit
210014
210004
306b00
210005
20006b
120700 // slower divisor
220007
10c400
100f00
4000c4
40000f
500100
210004
108000 // eighteen quick writes, one dropped
108100
108200
108300
108400
108500
108600
108700
108800
108900
108a00
108b00
108c00
108d00
108e00
108f00
109000
109100
210002 // tx full, not idle
400080
400081
400082
400083
400084
400085
400086
400087
400088
400089
40008a
40008b
40008c
40008d
40008e
40008f
400090
600c00 // dropped byte never sent
210004

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the uart controller testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module uart_controller_tb \
    -f uart_controller.f \
    -o uart_sim

out=$(./obj_dir/uart_sim 2>&1) || true
echo "$out"
grep -qx "Test OK" <<< "$out"

//--- uart_controller.f
design/uart_pkg.sv
design/uart_baud_gen.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_fifo.sv
design/uart_regs.sv
design/uart_controller.sv
dv/uart_controller_tb.sv
